//--- src/hbm_pkg.sv
// hbm model package: widths, bank timing constants, address layout and shared enums
`default_nettype none

package hbm_pkg;

  localparam int num_channels       = 2;
  localparam int channel_addr_width = 16;
  localparam int data_width         = 32;
  localparam int byte_offset_width  = 2;

  // channel address layout, row above bank above column
  localparam int col_lsb  = 2;
  localparam int col_msb  = 6;
  localparam int bank_lsb = 7;
  localparam int bank_msb = 8;
  localparam int row_lsb  = 9;
  localparam int row_msb  = 15;

  localparam int num_banks       = 4;
  localparam int word_addr_width = 14;

  // read latency from acceptance to data
  localparam int hit_latency  = 4;
  localparam int miss_latency = 10;

  // bank occupancy after an access
  localparam int hit_busy  = 2;
  localparam int miss_busy = 6;
  localparam int busy_width = $clog2(miss_busy + 1);

  localparam int queue_depth     = 8;
  localparam int queue_ptr_width = $clog2(queue_depth);
  localparam int cycle_width     = 16;

  typedef enum logic {cmd_read, cmd_write} hbm_cmd_e;

  typedef enum logic {bank_closed, bank_open} bank_state_e;

endpackage

`default_nettype wire

//--- src/hbm_bank_timing.sv
// hbm bank timing: accepts channel requests against open-row bank state and schedules reads
`timescale 1ns/1ps
`default_nettype none

module hbm_bank_timing import hbm_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          v_i,
  input  logic                          write_not_read_i,
  input  logic [channel_addr_width-1:0] ch_addr_i,
  input  logic                          data_v_i,
  input  logic                          queue_full_i,
  output logic                          accept_o,
  output logic [cycle_width-1:0]        due_o,
  output hbm_cmd_e                      cmd_o,
  output logic [word_addr_width-1:0]    word_addr_o
);

  logic [cycle_width-1:0] cycle_q;
  logic [cycle_width-1:0] last_due_q;
  logic                   last_due_live_q;

  bank_state_e                bank_state_q [num_banks];
  logic [row_msb-row_lsb:0]   open_row_q   [num_banks];
  logic [busy_width-1:0]      busy_q       [num_banks];

  logic [bank_msb-bank_lsb:0] bank;
  logic [row_msb-row_lsb:0]   row;
  logic                       row_hit;
  logic                       bank_free;
  logic                       read_accept;

  logic [cycle_width-1:0]        base_due;
  logic [cycle_width-1:0]        next_due;
  logic signed [cycle_width-1:0] due_gap;

  // address decode
  assign bank = ch_addr_i[bank_msb:bank_lsb];
  assign row  = ch_addr_i[row_msb:row_lsb];
  assign word_addr_o = {row, bank, ch_addr_i[col_msb:col_lsb]};

  assign cmd_o = write_not_read_i ? cmd_write : cmd_read;

  assign row_hit   = (bank_state_q[bank] == bank_open) && (open_row_q[bank] == row);
  assign bank_free = (busy_q[bank] == '0);

  // writes need their data, reads need a free queue slot
  always_comb begin
    accept_o = 1'b0;
    if (v_i && bank_free) begin
      if (write_not_read_i) begin
        accept_o = data_v_i;
      end else begin
        accept_o = !queue_full_i;
      end
    end
  end

  assign read_accept = accept_o && (cmd_o == cmd_read);

  // keep completions in order behind the last read still pending
  assign base_due = cycle_q + (row_hit ? cycle_width'(hit_latency) : cycle_width'(miss_latency));
  assign next_due = last_due_q + 1'b1;
  assign due_gap  = next_due - base_due;

  always_comb begin
    due_o = base_due;
    if (last_due_live_q && (due_gap > 0)) begin
      due_o = next_due;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycle_q         <= '0;
      last_due_q      <= '0;
      last_due_live_q <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      if (read_accept) begin
        last_due_q      <= due_o;
        last_due_live_q <= 1'b1;
      end else if (cycle_q == last_due_q) begin
        // last read has completed
        last_due_live_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < num_banks; b++) begin
      if (reset_i) begin
        bank_state_q[b] <= bank_closed;
        busy_q[b]       <= '0;
      end else if (accept_o && (bank == b)) begin
        bank_state_q[b] <= bank_open;
        busy_q[b]       <= row_hit ? busy_width'(hit_busy) : busy_width'(miss_busy);
      end else if (busy_q[b] != '0) begin
        busy_q[b] <= busy_q[b] - 1'b1;
      end
    end
  end

  // open row follows the last access of each bank
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      open_row_q[bank] <= row;
    end
  end

  a_accept_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    accept_o |-> v_i);

  a_no_read_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    queue_full_i |-> !read_accept);

endmodule

`default_nettype wire

//--- src/hbm_completion_queue.sv
// hbm completion queue: in-order FIFO of accepted reads that releases each one on its due cycle
`timescale 1ns/1ps
`default_nettype none

module hbm_completion_queue import hbm_pkg::*; (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       push_i,
  input  logic [cycle_width-1:0]     due_i,
  input  logic [word_addr_width-1:0] addr_i,
  output logic                       full_o,
  output logic                       done_v_o,
  output logic [word_addr_width-1:0] done_addr_o
);

  logic [cycle_width-1:0]     due_mem  [queue_depth];
  logic [word_addr_width-1:0] addr_mem [queue_depth];

  logic [queue_ptr_width-1:0] wr_ptr_q;
  logic [queue_ptr_width-1:0] rd_ptr_q;
  logic [queue_ptr_width:0]   count_q;
  logic [cycle_width-1:0]     cycle_q;

  logic                          pop;
  logic signed [cycle_width-1:0] order_gap;

  assign full_o = (count_q == (queue_ptr_width + 1)'(queue_depth));

  // head leaves exactly when the counter reaches its due cycle
  assign pop         = (count_q != '0) && (due_mem[rd_ptr_q] == cycle_q);
  assign done_v_o    = pop;
  assign done_addr_o = addr_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      cycle_q  <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      due_mem[wr_ptr_q]  <= due_i;
      addr_mem[wr_ptr_q] <= addr_i;
    end
  end

  // distance from the newest queued entry
  assign order_gap = due_i - due_mem[wr_ptr_q - 1'b1];

  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    full_o |-> !push_i);

  a_due_increasing: assert property (@(posedge clk_i) disable iff (reset_i)
    (push_i && (count_q != '0)) |-> (order_gap > 0));

endmodule

`default_nettype wire

//--- src/hbm_dram_channel.sv
// hbm dram channel: word storage with write data acceptance and registered read return
`timescale 1ns/1ps
`default_nettype none

module hbm_dram_channel import hbm_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          accept_i,
  input  hbm_cmd_e                      cmd_i,
  input  logic [word_addr_width-1:0]    word_addr_i,
  input  logic [data_width-1:0]         data_i,
  input  logic                          read_v_i,
  input  logic [word_addr_width-1:0]    read_addr_i,
  output logic                          data_yumi_o,
  output logic                          data_v_o,
  output logic [data_width-1:0]         data_o,
  output logic [channel_addr_width-1:0] ch_addr_o
);

  logic [data_width-1:0] mem_q [2**word_addr_width];

  logic [word_addr_width-1:0] clr_addr_q;
  logic                       clr_run_q;
  logic                       write_en;

  logic                       data_v_q;
  logic [data_width-1:0]      data_q;
  logic [word_addr_width-1:0] addr_q;

  // write data is taken together with its request
  assign write_en    = accept_i && (cmd_i == cmd_write);
  assign data_yumi_o = write_en;

  // clear sweep, first reset cycle loads the start address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if (clr_run_q) begin
        clr_addr_q <= clr_addr_q + 1'b1;
      end else begin
        clr_addr_q <= '0;
      end
      clr_run_q <= 1'b1;
    end else begin
      clr_run_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if (clr_run_q) begin
        mem_q[clr_addr_q] <= '0;
      end
    end else if (write_en) begin
      mem_q[word_addr_i] <= data_i;
    end
  end

  // read return
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_q <= 1'b0;
    end else begin
      data_v_q <= read_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_v_i) begin
      data_q <= mem_q[read_addr_i];
      addr_q <= read_addr_i;
    end
  end

  assign data_v_o  = data_v_q;
  assign data_o    = data_q;
  assign ch_addr_o = {addr_q, {byte_offset_width{1'b0}}};

  a_no_read_write_clash: assert property (@(posedge clk_i) disable iff (reset_i)
    (read_v_i && write_en) |-> (read_addr_i != word_addr_i));

endmodule

`default_nettype wire

//--- src/hbm_model.sv
// hbm model top: one bank timing, completion queue and storage slice per channel
`timescale 1ns/1ps
`default_nettype none

module hbm_model import hbm_pkg::*; (
  input  logic                                            clk_i,
  input  logic                                            reset_i,

  input  logic [num_channels-1:0]                         v_i,
  input  logic [num_channels-1:0]                         write_not_read_i,
  input  logic [num_channels-1:0][channel_addr_width-1:0] ch_addr_i,
  output logic [num_channels-1:0]                         yumi_o,

  input  logic [num_channels-1:0]                         data_v_i,
  input  logic [num_channels-1:0][data_width-1:0]         data_i,
  output logic [num_channels-1:0]                         data_yumi_o,

  output logic [num_channels-1:0]                         data_v_o,
  output logic [num_channels-1:0][data_width-1:0]         data_o,
  output logic [num_channels-1:0][channel_addr_width-1:0] ch_addr_o
);

  for (genvar i = 0; i < num_channels; i++) begin : g_ch
    logic                       accept;
    hbm_cmd_e                   cmd;
    logic [word_addr_width-1:0] word_addr;
    logic [cycle_width-1:0]     due;
    logic                       queue_full;
    logic                       push;
    logic                       done_v;
    logic [word_addr_width-1:0] done_addr;

    assign yumi_o[i] = accept;
    // only reads wait for completion
    assign push = accept && (cmd == cmd_read);

    hbm_bank_timing timing (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .v_i              (v_i[i]),
      .write_not_read_i (write_not_read_i[i]),
      .ch_addr_i        (ch_addr_i[i]),
      .data_v_i         (data_v_i[i]),
      .queue_full_i     (queue_full),
      .accept_o         (accept),
      .due_o            (due),
      .cmd_o            (cmd),
      .word_addr_o      (word_addr)
    );

    hbm_completion_queue queue (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (push),
      .due_i       (due),
      .addr_i      (word_addr),
      .full_o      (queue_full),
      .done_v_o    (done_v),
      .done_addr_o (done_addr)
    );

    hbm_dram_channel channel (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .accept_i    (accept),
      .cmd_i       (cmd),
      .word_addr_i (word_addr),
      .data_i      (data_i[i]),
      .read_v_i    (done_v),
      .read_addr_i (done_addr),
      .data_yumi_o (data_yumi_o[i]),
      .data_v_o    (data_v_o[i]),
      .data_o      (data_o[i]),
      .ch_addr_o   (ch_addr_o[i])
    );
  end

endmodule

`default_nettype wire

//--- bench/hbm_model_tb.sv
// hbm model testbench: directed and random channel traffic checked against a shadow memory
`timescale 1ns/1ps
`default_nettype none

module hbm_model_tb import hbm_pkg::*; ();

  localparam int timeout_cycles  = 500;
  localparam int clear_cycles    = 2**word_addr_width + 1;
  localparam int watchdog_ns     = 400_000;
  localparam int row_bits        = row_msb - row_lsb + 1;
  localparam int bank_bits       = bank_msb - bank_lsb + 1;
  localparam int col_bits        = col_msb - col_lsb + 1;

  logic                                            clk_i;
  logic                                            reset_i;
  logic [num_channels-1:0]                         v_i;
  logic [num_channels-1:0]                         write_not_read_i;
  logic [num_channels-1:0][channel_addr_width-1:0] ch_addr_i;
  logic [num_channels-1:0]                         yumi_o;
  logic [num_channels-1:0]                         data_v_i;
  logic [num_channels-1:0][data_width-1:0]         data_i;
  logic [num_channels-1:0]                         data_yumi_o;
  logic [num_channels-1:0]                         data_v_o;
  logic [num_channels-1:0][data_width-1:0]         data_o;
  logic [num_channels-1:0][channel_addr_width-1:0] ch_addr_o;

  // expected state of each channel
  logic [data_width-1:0]         shadow_mem [num_channels][2**word_addr_width];
  logic [row_bits-1:0]           open_row   [num_channels][num_banks];
  logic                          row_open   [num_channels][num_banks];
  logic [channel_addr_width-1:0] pending_q  [num_channels][$];
  int unsigned                   accept_cycle [num_channels];
  int unsigned                   return_cycle [num_channels];
  int unsigned                   cycle = 0;

  hbm_model DUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .v_i              (v_i),
    .write_not_read_i (write_not_read_i),
    .ch_addr_i        (ch_addr_i),
    .yumi_o           (yumi_o),
    .data_v_i         (data_v_i),
    .data_i           (data_i),
    .data_yumi_o      (data_yumi_o),
    .data_v_o         (data_v_o),
    .data_o           (data_o),
    .ch_addr_o        (ch_addr_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;
  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // idle-channel latency from the tracked open rows
  function automatic int expected_latency(input int ch, input logic [channel_addr_width-1:0] addr);
    logic [bank_bits-1:0] bank;
    bank = addr[bank_msb:bank_lsb];
    if (row_open[ch][bank] && (open_row[ch][bank] == addr[row_msb:row_lsb])) begin
      return hit_latency;
    end
    return miss_latency;
  endfunction

  function automatic logic read_in_flight(input int ch, input logic [channel_addr_width-1:0] addr);
    for (int i = 0; i < pending_q[ch].size(); i++) begin
      if (pending_q[ch][i][channel_addr_width-1:byte_offset_width]
          == addr[channel_addr_width-1:byte_offset_width]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_return(input int ch);
    logic [channel_addr_width-1:0] exp_addr;
    logic [data_width-1:0]         exp_data;
    if (data_v_o[ch]) begin
      assert (pending_q[ch].size() > 0) else begin
        $display("ERROR: channel %0d returned read data with no read outstanding", ch);
        abort_run();
      end
      exp_addr = pending_q[ch].pop_front();
      exp_data = shadow_mem[ch][exp_addr[channel_addr_width-1:byte_offset_width]];
      assert (ch_addr_o[ch] == exp_addr) else begin
        $display("FAILED ch_addr_o[%0d]: got 0x%04h expected 0x%04h", ch, ch_addr_o[ch], exp_addr);
        abort_run();
      end
      assert (data_o[ch] == exp_data) else begin
        $display("FAILED data_o[%0d]: got 0x%08h expected 0x%08h", ch, data_o[ch], exp_data);
        abort_run();
      end
      return_cycle[ch] = cycle;
    end
  endtask

  task automatic record_handshake(input int ch);
    logic [channel_addr_width-1:0] addr;
    logic [bank_bits-1:0]          bank;
    addr = ch_addr_i[ch];
    bank = addr[bank_msb:bank_lsb];
    assert (!yumi_o[ch] || v_i[ch]) else begin
      $display("ERROR: channel %0d raised yumi_o without a request", ch);
      abort_run();
    end
    if (v_i[ch] && write_not_read_i[ch]) begin
      assert (!yumi_o[ch] || data_v_i[ch]) else begin
        $display("ERROR: channel %0d acknowledged a write before its data was valid", ch);
        abort_run();
      end
    end
    assert (data_yumi_o[ch] == (yumi_o[ch] && write_not_read_i[ch])) else begin
      $display("FAILED data_yumi_o[%0d]: got 0x%0h expected 0x%0h", ch, data_yumi_o[ch],
               yumi_o[ch] && write_not_read_i[ch]);
      abort_run();
    end
    if (yumi_o[ch]) begin
      if (write_not_read_i[ch]) begin
        shadow_mem[ch][addr[channel_addr_width-1:byte_offset_width]] = data_i[ch];
      end else begin
        pending_q[ch].push_back({addr[channel_addr_width-1:byte_offset_width],
                                 {byte_offset_width{1'b0}}});
        accept_cycle[ch] = cycle;
      end
      open_row[ch][bank] = addr[row_msb:row_lsb];
      row_open[ch][bank] = 1'b1;
    end
  endtask

  // returns first so a read never sees a write from the same cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      for (int ch = 0; ch < num_channels; ch++) begin
        check_return(ch);
        record_handshake(ch);
      end
    end
  end

  task automatic settle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic issue_request(input int ch, input logic wr,
                               input logic [channel_addr_width-1:0] addr,
                               input logic [data_width-1:0] data, input int data_delay);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    v_i[ch] = 1'b1;
    write_not_read_i[ch] = wr;
    ch_addr_i[ch] = addr;
    data_i[ch] = data;
    data_v_i[ch] = wr && (data_delay == 0);
    while (!done) begin
      @(negedge clk_i);
      done = yumi_o[ch];
      @(posedge clk_i);
      #1;
      waited++;
      if (wr && (waited == data_delay)) begin
        data_v_i[ch] = 1'b1;
      end
      if (!done && (waited > timeout_cycles)) begin
        $display("ERROR: channel %0d request to 0x%04h was never acknowledged", ch, addr);
        abort_run();
      end
    end
    v_i[ch] = 1'b0;
    write_not_read_i[ch] = 1'b0;
    data_v_i[ch] = 1'b0;
  endtask

  task automatic wait_reads_done(input int ch);
    int waited;
    waited = 0;
    while (pending_q[ch].size() != 0) begin
      settle_cycles(1);
      waited++;
      if (waited > timeout_cycles) begin
        $display("ERROR: channel %0d reads did not complete in time", ch);
        abort_run();
      end
    end
  endtask

  task automatic check_quiet(input int n);
    repeat (n) begin
      @(negedge clk_i);
      assert ({yumi_o, data_yumi_o, data_v_o} == '0) else begin
        $display("FAILED yumi_o/data_yumi_o/data_v_o: got 0x%0h/0x%0h/0x%0h expected 0x0",
                 yumi_o, data_yumi_o, data_v_o);
        abort_run();
      end
    end
    settle_cycles(1);
  endtask

  task automatic check_read_latency(input int ch, input logic [channel_addr_width-1:0] addr);
    int exp_lat;
    int got_lat;
    exp_lat = expected_latency(ch, addr);
    issue_request(ch, 1'b0, addr, '0, 0);
    wait_reads_done(ch);
    // data_v_o rose one edge before the sample that saw it
    got_lat = int'(return_cycle[ch] - accept_cycle[ch]) - 1;
    assert (got_lat == exp_lat) else begin
      $display("FAILED read latency ch%0d: got 0x%0h expected 0x%0h", ch, got_lat, exp_lat);
      abort_run();
    end
    settle_cycles(miss_busy + 1);
  endtask

  task automatic random_traffic(input int ch, input int count);
    logic                          wr;
    logic [channel_addr_width-1:0] addr;
    logic [data_width-1:0]         data;
    int                            data_delay;
    int                            gap;
    for (int i = 0; i < count; i++) begin
      wr = 1'($urandom_range(0, 1));
      addr = {row_bits'($urandom_range(0, 3)), bank_bits'($urandom_range(0, num_banks - 1)),
              col_bits'($urandom_range(0, 31)), byte_offset_width'($urandom_range(0, 3))};
      // no write may overtake a read of the same word
      if (wr && read_in_flight(ch, addr)) begin
        wr = 1'b0;
      end
      data = $urandom();
      data_delay = $urandom_range(0, 2);
      gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 4)) : 0;
      issue_request(ch, wr, addr, data, data_delay);
      settle_cycles(gap);
    end
  endtask

  initial begin
    #(watchdog_ns);
    $display("ERROR: simulation watchdog expired");
    abort_run();
  end

  initial begin
    void'($urandom(71));
    reset_i = 1'b1;
    v_i = '0;
    write_not_read_i = '0;
    ch_addr_i = '0;
    data_v_i = '0;
    data_i = '0;
    for (int ch = 0; ch < num_channels; ch++) begin
      for (int w = 0; w < 2**word_addr_width; w++) begin
        shadow_mem[ch][w] = '0;
      end
      for (int b = 0; b < num_banks; b++) begin
        row_open[ch][b] = 1'b0;
        open_row[ch][b] = '0;
      end
    end
    // storage clears one word per reset cycle
    repeat (8) @(posedge clk_i);
    repeat (clear_cycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    check_quiet(20);
    issue_request(0, 1'b0, 16'h0000, '0, 0);
    issue_request(0, 1'b0, 16'hfffc, '0, 0);
    issue_request(1, 1'b0, 16'h1234, '0, 0);
    wait_reads_done(0);
    wait_reads_done(1);

    issue_request(1, 1'b1, 16'h1a37, 32'hdead_beef, 12);
    issue_request(1, 1'b0, 16'h1a36, '0, 0);
    wait_reads_done(1);
    settle_cycles(miss_busy + 1);

    for (int ch = 0; ch < num_channels; ch++) begin
      check_read_latency(ch, {7'h33, 2'd2, 5'd5, 2'd0});
      check_read_latency(ch, {7'h33, 2'd2, 5'd9, 2'd0});
    end

    fork
      issue_request(0, 1'b1, 16'h0840, 32'ha5a5_0001, 1);
      issue_request(1, 1'b1, 16'h0840, 32'h5a5a_0002, 0);
    join
    fork
      issue_request(0, 1'b0, 16'h0840, '0, 0);
      issue_request(1, 1'b0, 16'h0840, '0, 0);
    join
    wait_reads_done(0);
    wait_reads_done(1);

    fork
      random_traffic(0, 150);
      random_traffic(1, 150);
    join
    wait_reads_done(0);
    wait_reads_done(1);
    settle_cycles(4);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/hbm_pkg.sv
src/hbm_bank_timing.sv
src/hbm_completion_queue.sv
src/hbm_dram_channel.sv
src/hbm_model.sv
bench/hbm_model_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hbm_model_tb
SEED      ?= 71
LOG       ?= sim.log
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir

VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
